/* bbc_pkg.sv */
`default_nettype none

package bbc_pkg;

	// Bus widths
	localparam int CPU_AW = 16;
	localparam int DW = 8;
	localparam int DISP_AW = 15;
	localparam int MA_W = 14;
	localparam int RA_W = 5;

	// Read values of undecoded I/O
	localparam logic [7:0] SHEILA_UNUSED = 8'hFE;
	localparam logic [7:0] PAGE_UNUSED = 8'hFF;

	// I/O pages in the top of the map
	localparam logic [7:0] PAGE_FRED = 8'hFC;
	localparam logic [7:0] PAGE_JIM = 8'hFD;
	localparam logic [7:0] PAGE_SHEILA = 8'hFE;

	// Start of the shadowable screen area
	localparam logic [CPU_AW-1:0] SHADOW_LO = 16'h3000;
	localparam logic [CPU_AW-1:0] SHADOW_HI = 16'h7FFF;

	// ACCCON bit positions
	localparam int ACC_D = 0;
	localparam int ACC_E = 1;
	localparam int ACC_X = 2;
	localparam int ACC_Y = 3;
	localparam int ACC_IRR = 7;

	// Decoded memory region
	typedef enum logic [2:0] {
		REG_RAM = 3'd0,
		REG_ROM = 3'd1,
		REG_MOS = 3'd2,
		REG_FRED = 3'd3,
		REG_JIM = 3'd4,
		REG_SHEILA = 3'd5
	} region_e;

	// Registers handled in this glue, everything else in SHEILA is SH_NONE
	typedef enum logic [1:0] {
		SH_NONE = 2'd0,
		SH_ROMSEL = 2'd1,
		SH_ACCCON = 2'd2,
		SH_FDCON = 2'd3
	} sheila_reg_e;

endpackage

`default_nettype wire

/* bbc_clocks.sv */
`timescale 1ns/100ps
`default_nettype none

module bbc_clocks #(
	parameter int CLK_DIV = 24
) (
	input  wire  CLK48M_I,
	input  wire  reset_n,
	output logic cpu_clken_o,
	output logic phi0_o
);

	localparam int CW = $clog2(CLK_DIV);
	localparam logic [CW-1:0] LAST = CW'(CLK_DIV - 1);
	localparam logic [CW-1:0] HALF = CW'(CLK_DIV / 2);

	logic [CW-1:0] count;

	// Free running cycle counter, wraps every CPU cycle
	always_ff @(posedge CLK48M_I) begin
		if (!reset_n) begin
			count <= '0;
		end else if (count == LAST) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// Second half of the cycle belongs to the CPU
	assign phi0_o = (count >= HALF);

	// Strobe on the last master clock of the CPU half
	assign cpu_clken_o = (count == LAST);

endmodule

`default_nettype wire

/* bbc_addr_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module bbc_addr_decode
	import bbc_pkg::*;
(
	input  wire               model_i,
	input  wire  [CPU_AW-1:0] cpu_a_i,
	output region_e           region_o,
	output sheila_reg_e       sheila_reg_o
);

	// Memory region
	always_comb begin
		if (!cpu_a_i[15]) begin
			region_o = REG_RAM;
		end else if (!cpu_a_i[14]) begin
			region_o = REG_ROM;
		end else begin
			case (cpu_a_i[15:8])
				PAGE_FRED:   region_o = REG_FRED;
				PAGE_JIM:    region_o = REG_JIM;
				PAGE_SHEILA: region_o = REG_SHEILA;
				// C000-FBFF and FF00-FFFF
				default:     region_o = REG_MOS;
			endcase
		end
	end

	// Registers inside SHEILA
	always_comb begin
		sheila_reg_o = SH_NONE;
		if (cpu_a_i[15:8] == PAGE_SHEILA) begin
			if (cpu_a_i[7:0] inside {[8'h30:8'h33]}) begin
				sheila_reg_o = SH_ROMSEL;
			end else if (model_i && (cpu_a_i[7:0] inside {[8'h34:8'h37]})) begin
				sheila_reg_o = SH_ACCCON;
			end else if (model_i && (cpu_a_i[7:0] inside {[8'h24:8'h27]})) begin
				// Drive control only exists on the Master
				sheila_reg_o = SH_FDCON;
			end
		end
	end

endmodule

`default_nettype wire

/* bbc_sys_latches.sv */
`timescale 1ns/100ps
`default_nettype none

module bbc_sys_latches
	import bbc_pkg::*;
(
	input  wire               CLK48M_I,
	input  wire               reset_n,
	input  wire               model_i,
	input  wire               cpu_clken_i,
	input  wire  [CPU_AW-1:0] cpu_a_i,
	input  wire  [DW-1:0]     cpu_do_i,
	input  wire               cpu_r_nw_i,
	input  wire               cpu_sync_i,
	input  sheila_reg_e       sheila_reg_i,
	input  wire  [7:0]        sys_via_pb_i,
	output logic [DW-1:0]     romsel_o,
	output logic [DW-1:0]     acccon_o,
	output logic              vdu_op_o,
	output logic [1:0]        disp_offs_o,
	output logic              sound_enable_n_o,
	output logic              keyb_enable_n_o,
	output logic              caps_lock_led_n_o,
	output logic              shift_lock_led_n_o,
	output logic [3:0]        floppy_drive_o,
	output logic              floppy_side_o,
	output logic              floppy_reset_o,
	output logic              floppy_density_o
);

	logic [7:0] ic32;
	logic       cpu_wr;

	assign cpu_wr = cpu_clken_i & ~cpu_r_nw_i;

	// IC32 addressable latch, PB2..0 selects the bit and PB3 is the value
	always_ff @(posedge CLK48M_I) begin
		if (!reset_n) begin
			ic32 <= '0;
		end else begin
			ic32[sys_via_pb_i[2:0]] <= sys_via_pb_i[3];
		end
	end

	assign sound_enable_n_o = ic32[0];
	assign keyb_enable_n_o = ic32[3];
	assign disp_offs_o = ic32[5:4];
	assign caps_lock_led_n_o = ic32[6];
	assign shift_lock_led_n_o = ic32[7];

	// ROM select, ACCCON and opcode fetch tracking
	always_ff @(posedge CLK48M_I) begin
		if (!reset_n) begin
			romsel_o <= '0;
			acccon_o <= '0;
			vdu_op_o <= 1'b0;
		end else if (cpu_clken_i) begin
			if (cpu_wr && sheila_reg_i == SH_ROMSEL) begin
				// Model B has no RAM bank bit
				romsel_o <= {cpu_do_i[7] & model_i, cpu_do_i[6:0]};
			end
			if (cpu_wr && sheila_reg_i == SH_ACCCON) begin
				acccon_o <= cpu_do_i;
			end
			// Last opcode came from the VDU driver area C000-DFFF
			if (cpu_sync_i) begin
				vdu_op_o <= (cpu_a_i[15:13] == 3'b110);
			end
		end
	end

	// Master drive control
	always_ff @(posedge CLK48M_I) begin
		if (!reset_n) begin
			floppy_drive_o <= 4'b1111;
			floppy_side_o <= 1'b0;
			floppy_reset_o <= 1'b0;
			floppy_density_o <= 1'b0;
		end else if (cpu_wr && sheila_reg_i == SH_FDCON) begin
			floppy_drive_o <= {2'b11, ~cpu_do_i[1:0]};
			floppy_reset_o <= cpu_do_i[2];
			floppy_side_o <= ~cpu_do_i[4];
			floppy_density_o <= cpu_do_i[5];
		end
	end

endmodule

`default_nettype wire

/* bbc_display_addr.sv */
`timescale 1ns/100ps
`default_nettype none

module bbc_display_addr
	import bbc_pkg::*;
(
	input  wire  [MA_W-1:0]    crtc_ma_i,
	input  wire  [RA_W-1:0]    crtc_ra_i,
	input  wire  [1:0]         disp_offs_i,
	output logic [DISP_AW-1:0] disp_a_o
);

	logic [3:0] adj;
	logic [3:0] nib;

	// Wrap offset per screen size
	always_comb begin
		case (disp_offs_i)
			// Mode 3, restart at 4000
			2'b00:   adj = 4'd8;
			// Mode 6, restart at 6000
			2'b01:   adj = 4'd12;
			// Modes 0 to 2, restart at 3000
			2'b10:   adj = 4'd6;
			// Modes 4 and 5, restart at 5800
			default: adj = 4'd11;
		endcase
	end

	// Addresses past the top of RAM fold back into the screen area
	assign nib = crtc_ma_i[12] ? crtc_ma_i[11:8] + adj : crtc_ma_i[11:8];

	// Teletext reads a 1K page at 7C00, bitmap modes use the row address
	assign disp_a_o = crtc_ma_i[13] ? {nib[3], 4'b1111, crtc_ma_i[9:0]} :
		{nib, crtc_ma_i[7:0], crtc_ra_i[2:0]};

endmodule

`default_nettype wire

/* bbc_glue.sv */
`timescale 1ns/100ps
`default_nettype none

module bbc_glue
	import bbc_pkg::*;
#(
	parameter int CLK_DIV = 24
) (
	input  wire               CLK48M_I,
	input  wire               reset_n,
	input  wire               model_i,
	input  wire  [CPU_AW-1:0] cpu_a_i,
	input  wire  [DW-1:0]     cpu_do_i,
	input  wire               cpu_r_nw_i,
	input  wire               cpu_sync_i,
	input  wire  [7:0]        sys_via_pb_i,
	input  wire  [MA_W-1:0]   crtc_ma_i,
	input  wire  [RA_W-1:0]   crtc_ra_i,
	input  wire  [DW-1:0]     mem_di_i,
	output logic              cpu_clken_o,
	output logic              phi0_o,
	output logic [DW-1:0]     cpu_di_o,
	output logic [CPU_AW-1:0] mem_adr_o,
	output logic              mem_we_o,
	output logic [DW-1:0]     mem_do_o,
	output logic [DW-1:0]     romsel_o,
	output logic              shadow_ram_o,
	output logic              shadow_vid_o,
	output logic              acc_y_o,
	output logic              irq_req_o,
	output logic              sound_enable_n_o,
	output logic              keyb_enable_n_o,
	output logic              caps_lock_led_n_o,
	output logic              shift_lock_led_n_o,
	output logic [3:0]        floppy_drive_o,
	output logic              floppy_side_o,
	output logic              floppy_reset_o,
	output logic              floppy_density_o
);

	region_e            region;
	sheila_reg_e        sheila_reg;
	logic [DW-1:0]      acccon;
	logic               vdu_op;
	logic [1:0]         disp_offs;
	logic [DISP_AW-1:0] disp_a;
	logic               in_shadow;

	bbc_clocks #(
		.CLK_DIV(CLK_DIV)
	) u_clocks (
		.CLK48M_I   (CLK48M_I),
		.reset_n    (reset_n),
		.cpu_clken_o(cpu_clken_o),
		.phi0_o     (phi0_o)
	);

	bbc_addr_decode u_decode (
		.model_i     (model_i),
		.cpu_a_i     (cpu_a_i),
		.region_o    (region),
		.sheila_reg_o(sheila_reg)
	);

	bbc_sys_latches u_latches (
		.CLK48M_I          (CLK48M_I),
		.reset_n           (reset_n),
		.model_i           (model_i),
		.cpu_clken_i       (cpu_clken_o),
		.cpu_a_i           (cpu_a_i),
		.cpu_do_i          (cpu_do_i),
		.cpu_r_nw_i        (cpu_r_nw_i),
		.cpu_sync_i        (cpu_sync_i),
		.sheila_reg_i      (sheila_reg),
		.sys_via_pb_i      (sys_via_pb_i),
		.romsel_o          (romsel_o),
		.acccon_o          (acccon),
		.vdu_op_o          (vdu_op),
		.disp_offs_o       (disp_offs),
		.sound_enable_n_o  (sound_enable_n_o),
		.keyb_enable_n_o   (keyb_enable_n_o),
		.caps_lock_led_n_o (caps_lock_led_n_o),
		.shift_lock_led_n_o(shift_lock_led_n_o),
		.floppy_drive_o    (floppy_drive_o),
		.floppy_side_o     (floppy_side_o),
		.floppy_reset_o    (floppy_reset_o),
		.floppy_density_o  (floppy_density_o)
	);

	bbc_display_addr u_disp (
		.crtc_ma_i  (crtc_ma_i),
		.crtc_ra_i  (crtc_ra_i),
		.disp_offs_i(disp_offs),
		.disp_a_o   (disp_a)
	);

	// CPU read data
	always_comb begin
		case (region)
			REG_RAM, REG_ROM, REG_MOS: cpu_di_o = mem_di_i;
			REG_SHEILA: begin
				if (sheila_reg == SH_ACCCON) begin
					cpu_di_o = acccon;
				end else if (sheila_reg == SH_ROMSEL && model_i) begin
					cpu_di_o = romsel_o;
				end else begin
					cpu_di_o = SHEILA_UNUSED;
				end
			end
			default: cpu_di_o = PAGE_UNUSED;
		endcase
	end

	// Shadow screen RAM at 3000-7FFF
	assign in_shadow = (cpu_a_i >= SHADOW_LO) && (cpu_a_i <= SHADOW_HI);
	assign shadow_ram_o = in_shadow &&
		(acccon[ACC_X] || (acccon[ACC_E] && vdu_op && !cpu_sync_i));

	assign shadow_vid_o = acccon[ACC_D];
	assign acc_y_o = acccon[ACC_Y];
	assign irq_req_o = acccon[ACC_IRR];

	// CPU owns the memory bus while phi0 is high, video otherwise
	assign mem_adr_o = phi0_o ? cpu_a_i : {{(CPU_AW - DISP_AW){1'b0}}, disp_a};
	assign mem_we_o = phi0_o & ~cpu_r_nw_i;
	assign mem_do_o = cpu_do_i;

endmodule

`default_nettype wire

/* bbc_glue_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module bbc_glue_chk
	import bbc_pkg::*;
(
	input  wire          CLK48M_I,
	input  wire          reset_n,
	input  wire          model_i,
	input  wire          cpu_clken_i,
	input  wire          phi0_i,
	input  wire          mem_we_i,
	input  wire [DW-1:0] romsel_i
);

	int fail_count = 0;

	// Strobe sits at the end of the CPU half cycle
	clken_in_phi0: assert property (@(posedge CLK48M_I) disable iff (!reset_n)
		cpu_clken_i |-> phi0_i)
		else begin
			$error("cpu_clken_o high while phi0_o low");
			fail_count++;
		end

	// Video owns the bus in the other half
	we_in_phi0: assert property (@(posedge CLK48M_I) disable iff (!reset_n)
		mem_we_i |-> phi0_i)
		else begin
			$error("mem_we_o high while phi0_o low");
			fail_count++;
		end

	// No RAM bank bit on Model B
	no_bank_bit_model_b: assert property (@(posedge CLK48M_I) disable iff (!reset_n)
		!model_i |-> !romsel_i[7])
		else begin
			$error("romsel_o bit 7 set on Model B");
			fail_count++;
		end

endmodule

bind bbc_glue bbc_glue_chk u_chk (
	.CLK48M_I   (CLK48M_I),
	.reset_n    (reset_n),
	.model_i    (model_i),
	.cpu_clken_i(cpu_clken_o),
	.phi0_i     (phi0_o),
	.mem_we_i   (mem_we_o),
	.romsel_i   (romsel_o)
);

`default_nettype wire

/* tb_bbc_glue.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_bbc_glue
	import bbc_pkg::*;
();

	localparam int CLK_DIV = 8;
	// Tests take under 1000 cycles, so this leaves ample margin
	localparam int MAX_CYCLES = 4000;
	localparam logic [31:0] SEED = 32'h1d55;

	logic               clk48m;
	logic               reset_n;
	logic               model;
	logic [CPU_AW-1:0]  cpu_a;
	logic [DW-1:0]      cpu_do;
	logic               cpu_r_nw;
	logic               cpu_sync;
	logic [7:0]         sys_via_pb;
	logic [MA_W-1:0]    crtc_ma;
	logic [RA_W-1:0]    crtc_ra;
	logic [DW-1:0]      mem_di;
	logic               cpu_clken;
	logic               phi0;
	logic [DW-1:0]      cpu_di;
	logic [CPU_AW-1:0]  mem_adr;
	logic               mem_we;
	logic [DW-1:0]      mem_do;
	logic [DW-1:0]      romsel;
	logic               shadow_ram;
	logic               shadow_vid;
	logic               acc_y;
	logic               irq_req;
	logic               sound_en_n;
	logic               keyb_en_n;
	logic               caps_led_n;
	logic               shift_led_n;
	logic [3:0]         fd_drive;
	logic               fd_side;
	logic               fd_reset;
	logic               fd_density;

	// Expected contents of IC32
	logic [7:0]         ic_model;
	int                 cycle_count;

	bbc_glue #(
		.CLK_DIV(CLK_DIV)
	) dut0 (
		.CLK48M_I          (clk48m),
		.reset_n           (reset_n),
		.model_i           (model),
		.cpu_a_i           (cpu_a),
		.cpu_do_i          (cpu_do),
		.cpu_r_nw_i        (cpu_r_nw),
		.cpu_sync_i        (cpu_sync),
		.sys_via_pb_i      (sys_via_pb),
		.crtc_ma_i         (crtc_ma),
		.crtc_ra_i         (crtc_ra),
		.mem_di_i          (mem_di),
		.cpu_clken_o       (cpu_clken),
		.phi0_o            (phi0),
		.cpu_di_o          (cpu_di),
		.mem_adr_o         (mem_adr),
		.mem_we_o          (mem_we),
		.mem_do_o          (mem_do),
		.romsel_o          (romsel),
		.shadow_ram_o      (shadow_ram),
		.shadow_vid_o      (shadow_vid),
		.acc_y_o           (acc_y),
		.irq_req_o         (irq_req),
		.sound_enable_n_o  (sound_en_n),
		.keyb_enable_n_o   (keyb_en_n),
		.caps_lock_led_n_o (caps_led_n),
		.shift_lock_led_n_o(shift_led_n),
		.floppy_drive_o    (fd_drive),
		.floppy_side_o     (fd_side),
		.floppy_reset_o    (fd_reset),
		.floppy_density_o  (fd_density)
	);

	always #50 clk48m = ~clk48m;

	always @(posedge clk48m) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("TIMEOUT: the tests did not finish within %0d clock cycles", MAX_CYCLES);
			$display("STATUS: FAIL");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("ERROR: time %0t: %s: got %0h, expected %0h", $time, what, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// Back to the drive point just after the next rising edge
	task automatic hold_cycle();
		@(posedge clk48m);
		#10;
	endtask

	// Runs until the edge that ends the current CPU cycle
	task automatic wait_strobe();
		while (!cpu_clken) begin
			hold_cycle();
		end
		hold_cycle();
	endtask

	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		cpu_a = addr;
		cpu_do = data;
		cpu_r_nw = 1'b0;
		wait_strobe();
		cpu_r_nw = 1'b1;
	endtask

	task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
		cpu_a = addr;
		cpu_r_nw = 1'b1;
		#20;
		data = cpu_di;
		hold_cycle();
	endtask

	task automatic opcode_fetch(input logic [15:0] addr);
		cpu_a = addr;
		cpu_r_nw = 1'b1;
		cpu_sync = 1'b1;
		wait_strobe();
		cpu_sync = 1'b0;
	endtask

	task automatic set_ic32_bit(input logic [2:0] sel, input logic v);
		sys_via_pb = {4'b0000, v, sel};
		hold_cycle();
		ic_model[sel] = v;
	endtask

	task automatic check_shadow(input logic [15:0] addr, input logic sync, input logic exp,
		input string what);
		cpu_a = addr;
		cpu_sync = sync;
		#20;
		check(32'(shadow_ram), 32'(exp), what);
		// Keep sync low across the edge so vdu_op is left alone
		cpu_sync = 1'b0;
		hold_cycle();
	endtask

	task automatic apply_reset(input logic m);
		reset_n = 1'b0;
		sys_via_pb = 8'h00;
		hold_cycle();
		model = m;
		ic_model = 8'h00;
		repeat (7) begin
			hold_cycle();
		end
		reset_n = 1'b1;
	endtask

	// Screen wrap rule for the high nibble of the CRTC address
	function automatic logic [14:0] screen_addr(input logic [13:0] ma, input logic [4:0] ra,
		input logic [1:0] offs);
		logic [3:0] step;
		logic [3:0] nib;
		case (offs)
			2'b00: step = 4'd8;
			2'b01: step = 4'd12;
			2'b10: step = 4'd6;
			default: step = 4'd11;
		endcase
		nib = ma[11:8];
		if (ma[12]) begin
			nib = nib + step;
		end
		if (ma[13]) begin
			screen_addr = {nib[3], 4'b1111, ma[9:0]};
		end else begin
			screen_addr = {nib, ma[7:0], ra[2:0]};
		end
	endfunction

	task automatic test_clocks();
		reset_n = 1'b0;
		repeat (8) begin
			hold_cycle();
			check(32'(cpu_clken), 0, "cpu_clken_o in reset");
			check(32'(phi0), 0, "phi0_o in reset");
		end
		reset_n = 1'b1;
		check(32'(cpu_clken), 0, "cpu_clken_o after reset");
		check(32'(phi0), 0, "phi0_o after reset");
		// Counter position is the edge count since release, modulo 8
		for (int n = 1; n <= 24; n++) begin
			hold_cycle();
			check(32'(cpu_clken), 32'((n % 8) == 7), "cpu_clken_o spacing");
			check(32'(phi0), 32'((n % 8) >= 4), "phi0_o high half");
		end
		cpu_a = 16'h0100;
		cpu_do = 8'h5A;
		cpu_r_nw = 1'b0;
		for (int k = 0; k < 16; k++) begin
			#20;
			check(32'(mem_we), 32'((k % 8) >= 4), "mem_we_o during a write");
			check(32'(mem_do), 32'h5A, "mem_do_o");
			hold_cycle();
		end
		cpu_r_nw = 1'b1;
		#20;
		check(32'(mem_we), 0, "mem_we_o during a read");
		hold_cycle();
	endtask

	task automatic test_romsel();
		logic [7:0] b;
		logic [7:0] rd;
		repeat (8) begin
			b = 8'($urandom());
			bus_write(16'hFE30 | 16'($urandom() & 3), b);
			check(32'(romsel), 32'(b), "romsel_o on Master");
			bus_read(16'hFE30, rd);
			check(32'(rd), 32'(b), "ROMSEL readback on Master");
		end
		apply_reset(1'b0);
		repeat (6) begin
			b = 8'($urandom()) | 8'h80;
			bus_write(16'hFE30 | 16'($urandom() & 3), b);
			check(32'(romsel), 32'({1'b0, b[6:0]}), "romsel_o on Model B");
			bus_read(16'hFE30, rd);
			check(32'(rd), 32'hFE, "ROMSEL read on Model B");
		end
		apply_reset(1'b1);
	endtask

	task automatic test_ic32();
		repeat (24) begin
			set_ic32_bit(3'($urandom()), 1'($urandom()));
			check(32'(sound_en_n), 32'(ic_model[0]), "sound enable");
			check(32'(keyb_en_n), 32'(ic_model[3]), "keyboard enable");
			check(32'(caps_led_n), 32'(ic_model[6]), "caps lock LED");
			check(32'(shift_led_n), 32'(ic_model[7]), "shift lock LED");
		end
	endtask

	task automatic test_display();
		logic [13:0] ma;
		logic [4:0]  ra;
		logic [15:0] a;
		repeat (4) begin
			set_ic32_bit(3'd4, 1'($urandom()));
			set_ic32_bit(3'd5, 1'($urandom()));
			repeat (8) begin
				while (phi0) begin
					hold_cycle();
				end
				ma = 14'($urandom());
				ra = 5'($urandom());
				a = 16'($urandom());
				crtc_ma = ma;
				crtc_ra = ra;
				cpu_a = a;
				#20;
				check(32'(mem_adr), 32'({1'b0, screen_addr(ma, ra, ic_model[5:4])}),
					"video address");
				hold_cycle();
				while (!phi0) begin
					hold_cycle();
				end
				#20;
				check(32'(mem_adr), 32'(a), "CPU address while phi0 high");
				hold_cycle();
			end
		end
		cpu_a = 16'h0000;
	endtask

	task automatic test_acccon();
		logic [7:0]  v;
		logic [7:0]  rd;
		logic [15:0] vdu_a;
		repeat (6) begin
			v = 8'($urandom());
			bus_write(16'hFE34 | 16'($urandom() & 3), v);
			bus_read(16'hFE34, rd);
			check(32'(rd), 32'(v), "ACCCON readback");
			check(32'(shadow_vid), 32'(v[0]), "shadow_vid_o");
			check(32'(acc_y), 32'(v[3]), "acc_y_o");
			check(32'(irq_req), 32'(v[7]), "irq_req_o");
		end
		// X bit maps the whole shadow area
		bus_write(16'hFE34, 8'h04);
		check_shadow(16'h3000, 1'b0, 1'b1, "shadow at 3000 with X");
		check_shadow(16'h7FFF, 1'b0, 1'b1, "shadow at 7FFF with X");
		check_shadow(16'h3000 + 16'($urandom() % 32'h5000), 1'b0, 1'b1, "shadow inside with X");
		check_shadow(16'h2FFF, 1'b0, 1'b0, "shadow at 2FFF with X");
		check_shadow(16'h8000, 1'b0, 1'b0, "shadow at 8000 with X");
		// E bit only for code running in the VDU area
		bus_write(16'hFE34, 8'h02);
		check_shadow(16'h4000, 1'b0, 1'b0, "shadow with E before any fetch");
		vdu_a = 16'hC000 | 16'($urandom() & 32'h1FFF);
		opcode_fetch(vdu_a);
		check_shadow(16'h4000, 1'b0, 1'b1, "shadow with E after VDU fetch");
		check_shadow(16'h4000, 1'b1, 1'b0, "shadow with E during a fetch");
		check_shadow(16'h9000, 1'b0, 1'b0, "shadow with E outside area");
		opcode_fetch(16'hE000 | 16'($urandom() & 32'h1FFF));
		check_shadow(16'h4000, 1'b0, 1'b0, "shadow with E after MOS fetch");
		check_shadow(16'h4000, 1'b1, 1'b0, "shadow with E, sync, MOS fetch");
		opcode_fetch(vdu_a);
		check_shadow(16'h5000, 1'b0, 1'b1, "shadow with E after second VDU fetch");
		opcode_fetch(16'h2000);
		check_shadow(16'h5000, 1'b0, 1'b0, "shadow with E after RAM fetch");
		bus_write(16'hFE34, 8'h00);
	endtask

	task automatic test_floppy_reads();
		logic [7:0] d;
		logic [7:0] md;
		logic [7:0] rd;
		repeat (6) begin
			d = 8'($urandom());
			bus_write(16'hFE24 | 16'($urandom() & 3), d);
			check(32'(fd_drive), 32'({2'b11, ~d[1:0]}), "floppy drive select");
			check(32'(fd_side), 32'(!d[4]), "floppy side");
			check(32'(fd_reset), 32'(d[2]), "floppy reset");
			check(32'(fd_density), 32'(d[5]), "floppy density");
		end
		repeat (4) begin
			md = 8'($urandom());
			mem_di = md;
			bus_read(16'($urandom() & 32'h7FFF), rd);
			check(32'(rd), 32'(md), "RAM read");
			bus_read(16'h8000 | 16'($urandom() & 32'h3FFF), rd);
			check(32'(rd), 32'(md), "ROM read");
			bus_read(16'hC000 + 16'($urandom() % 32'h3C00), rd);
			check(32'(rd), 32'(md), "MOS read below FC00");
			bus_read(16'hFF00 | 16'($urandom() & 32'hFF), rd);
			check(32'(rd), 32'(md), "MOS read in FFxx");
			bus_read(16'hFC00 | 16'($urandom() & 32'hFF), rd);
			check(32'(rd), 32'hFF, "FRED read");
			bus_read(16'hFD00 | 16'($urandom() & 32'hFF), rd);
			check(32'(rd), 32'hFF, "JIM read");
			bus_read(16'hFE40 + 16'($urandom() % 32'hC0), rd);
			check(32'(rd), 32'hFE, "unused SHEILA read above FE40");
			bus_read(16'hFE00 | 16'($urandom() & 32'h1F), rd);
			check(32'(rd), 32'hFE, "unused SHEILA read below FE20");
		end
	endtask

	initial begin
		clk48m = 1'b0;
		reset_n = 1'b0;
		model = 1'b1;
		cpu_a = '0;
		cpu_do = '0;
		cpu_r_nw = 1'b1;
		cpu_sync = 1'b0;
		sys_via_pb = 8'h00;
		crtc_ma = '0;
		crtc_ra = '0;
		mem_di = '0;
		ic_model = 8'h00;
		cycle_count = 0;
		void'($urandom(SEED));

		test_clocks();
		test_romsel();
		test_ic32();
		test_display();
		test_acccon();
		test_floppy_reads();

		if (dut0.u_chk.fail_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("%0d bound assertions failed during the run", dut0.u_chk.fail_count);
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
bbc_pkg.sv
bbc_clocks.sv
bbc_addr_decode.sv
bbc_sys_latches.sv
bbc_display_addr.sv
bbc_glue.sv
bbc_glue_chk.sv
tb_bbc_glue.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line in the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_bbc_glue -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
	exit 0
fi
exit 1
